// File: src.f
hdl/vcfg_pkg.sv
hdl/elem_pipe_pkg.sv
hdl/elem_counter.sv
hdl/flush_tracker.sv
hdl/result_writer.sv
hdl/elem_writeback.sv
tests/elem_writeback_tb.sv

// File: Makefile
# Verilator build and run of the element writeback testbench
VERILATOR ?= verilator
TOP       ?= elem_writeback_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/elem_writeback_tb.sv
// ----------------------------------------------------------------------
// table-driven testbench of the element writeback path with a model
// of the byte counting, vreg address and completion rules
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module elem_writeback_tb;

        localparam int VREG_W  = 128;
        localparam int VREG_B  = VREG_W / 8;     // bytes per vreg
        localparam int CNT_MOD = VREG_B * 8;     // group of up to 8 vregs

        typedef struct packed {
                elem_pipe_pkg::elem_beat_t beat;
                logic                      valid;
                logic                      ready;
                logic [7:0]                spec;
                logic [7:0]                killed;
                logic                      exp_out_valid;
                logic                      exp_beat_ready;
                logic                      exp_xreg_valid;
        } row_t;

        logic                      clk_i = 1'b0;
        logic                      async_rst_ni;
        logic                      beat_valid_i;
        elem_pipe_pkg::elem_beat_t beat_i;
        logic                      beat_ready_o;
        logic                      out_valid_o;
        logic                      out_ready_i;
        elem_pipe_pkg::wb_req_t    wb_o;
        logic [7:0]                instr_spec_i;
        logic [7:0]                instr_killed_i;
        elem_pipe_pkg::xreg_wr_t   xreg_o;
        logic                      instr_done_o;
        logic                      pend_clear_o;
        vcfg_pkg::emul_e           pend_clear_cnt_o;

        row_t                      rows_q[$];
        logic [31:0]               rnd = 32'ha8a4;
        int                        errors = 0;
        int                        checks = 0;
        int                        cycles = 0;
        int                        limit = 1000;
        int                        m_cnt = 0;    // model of the byte counter
        logic                      m_has = 1'b0;
        logic                      m_flush = 1'b0;
        elem_pipe_pkg::elem_beat_t m_ctx = '0;   // beat that started the flush

        elem_writeback #(.VREG_W(VREG_W)) DUT (.*);

        always #20 clk_i = ~clk_i;

        always @(posedge clk_i) begin
                cycles++;
                if (cycles > limit) begin
                        $display("timeout, row loop still running after %0d cycles", cycles);
                        $display("Test failures found");
                        $finish;
                end
        end

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                return y ^ (y << 5);
        endfunction

        task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
                checks++;
                if (exp !== act) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                                 $time, name, exp, act);
                end
        endtask

        task automatic push(input elem_pipe_pkg::elem_beat_t b, input logic v, input logic rdy,
                            input logic [7:0] spec, input logic [7:0] kill, input logic ov,
                            input logic br, input logic xv);
                rows_q.push_back({b, v, rdy, spec, kill, ov, br, xv});
        endtask

        task automatic make_beat(output elem_pipe_pkg::elem_beat_t b, input logic [2:0] id,
                                 input vcfg_pkg::vsew_e eew, input vcfg_pkg::emul_e emul,
                                 input logic [4:0] vaddr, input logic first, input logic last,
                                 input logic rflush, input logic res_valid, input logic xv);
                rnd = xorshift(rnd);
                b = {id, eew, emul, vaddr, first, last, rflush, xv, res_valid, xv,
                     rnd, rnd[3:0], rnd[12:8], ~rnd};
        endtask

        initial begin
                elem_pipe_pkg::elem_beat_t b;
                row_t r;
                int   i;
                int   j;
                int   bytes;
                int   cnt;
                int   exp_vaddr;
                logic full;
                logic last_plain;
                logic exp_clear;

                async_rst_ni   = 1'b0;
                beat_valid_i   = 1'b0;
                beat_i         = '0;
                out_ready_i    = 1'b1;
                instr_spec_i   = '0;
                instr_killed_i = '0;

                for (i = 0; i < 3; i++) begin
                        push('0, 1'b0, 1'b1, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0); // idle after reset
                end
                for (i = 0; i < 4; i++) begin
                        make_beat(b, 3'd1, vcfg_pkg::VSEW_32, vcfg_pkg::EMUL_1, 5'd4,
                                  i == 0, i == 3, 1'b0, 1'b1, 1'b0);
                        push(b, 1'b1, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0);
                end
                for (i = 0; i < 32; i++) begin
                        make_beat(b, 3'd2, vcfg_pkg::VSEW_8, vcfg_pkg::EMUL_2, 5'd10,
                                  i == 0, i == 31, 1'b0, 1'b1, 1'b0);
                        push(b, 1'b1, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0);
                end
                // reduction with six results then a padded group
                for (i = 0; i < 6; i++) begin
                        make_beat(b, 3'd3, vcfg_pkg::VSEW_8, vcfg_pkg::EMUL_1, 5'd8,
                                  i == 0, 1'b0, 1'b0, 1'b1, 1'b0);
                        push(b, 1'b1, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0);
                end
                make_beat(b, 3'd3, vcfg_pkg::VSEW_8, vcfg_pkg::EMUL_1, 5'd8,
                          1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
                push(b, 1'b1, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0);
                // stale beat content on the idle input while the group is padded
                make_beat(b, 3'd0, vcfg_pkg::VSEW_32, vcfg_pkg::EMUL_8, 5'd0,
                          1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
                for (i = 0; i < 10; i++) begin
                        push(b, 1'b0, 1'b1, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
                end
                push('0, 1'b0, 1'b1, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
                // scalar result held back, released, then killed
                make_beat(b, 3'd2, vcfg_pkg::VSEW_32, vcfg_pkg::EMUL_1, 5'd0,
                          1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                push(b, 1'b1, 1'b1, 8'h04, 8'h00, 1'b0, 1'b0, 1'b0);
                push(b, 1'b1, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1);
                push(b, 1'b1, 1'b1, 8'h00, 8'h04, 1'b1, 1'b1, 1'b0);
                make_beat(b, 3'd6, vcfg_pkg::VSEW_32, vcfg_pkg::EMUL_1, 5'd0,
                          1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
                push(b, 1'b1, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1);
                for (i = 0; i < 4; i++) begin
                        make_beat(b, 3'd5, vcfg_pkg::VSEW_32, vcfg_pkg::EMUL_1, 5'd20,
                                  i == 0, i == 3, 1'b0, 1'b1, 1'b0);
                        for (j = 0; j < ((i == 2) ? 3 : 0); j++) begin
                                push(b, 1'b1, 1'b0, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0); // back-pressure
                        end
                        push(b, 1'b1, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0);
                end
                push('0, 1'b0, 1'b1, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0);
                limit = rows_q.size() + 10 + 50;

                repeat (10) @(posedge clk_i);
                @(negedge clk_i);
                async_rst_ni = 1'b1;

                foreach (rows_q[k]) begin
                        r = rows_q[k];
                        @(negedge clk_i);
                        beat_valid_i   = r.valid;
                        beat_i         = r.beat;
                        out_ready_i    = r.ready;
                        instr_spec_i   = r.spec;
                        instr_killed_i = r.killed;
                        #5;
                        bytes = 1 << int'(m_flush ? m_ctx.eew : r.beat.eew);
                        if (!m_flush && r.beat.res_valid && (r.beat.first_cycle || !m_has)) begin
                                cnt = bytes - 1; // last byte of element 0
                        end else if (m_flush || r.beat.res_valid) begin
                                cnt = (m_cnt + bytes) % CNT_MOD;
                        end else begin
                                cnt = m_cnt;
                        end
                        full       = (cnt % VREG_B) == VREG_B - 1;
                        last_plain = r.valid && !m_flush && r.beat.last_cycle &&
                                     !r.beat.requires_flush;
                        exp_clear  = (last_plain && !r.beat.xreg) || (m_flush && full);
                        exp_vaddr  = int'(m_flush ? m_ctx.vaddr : r.beat.vaddr) | ((cnt / VREG_B) &
                                     ((1 << int'(m_flush ? m_ctx.emul : r.beat.emul)) - 1));

                        check("out_valid_o", 32'(r.exp_out_valid), 32'(out_valid_o));
                        check("beat_ready_o", 32'(r.exp_beat_ready), 32'(beat_ready_o));
                        check("xreg_o.valid", 32'(r.exp_xreg_valid), 32'(xreg_o.valid));
                        check("instr_done_o", 32'(last_plain || (m_flush && full)),
                              32'(instr_done_o));
                        check("pend_clear_o", 32'(exp_clear), 32'(pend_clear_o));
                        if (exp_clear) begin
                                check("pend_clear_cnt_o",
                                      32'(m_flush ? m_ctx.emul : r.beat.emul),
                                      32'(pend_clear_cnt_o));
                        end
                        if (r.exp_out_valid) begin
                                check("wb_o.id", 32'(m_flush ? m_ctx.id : r.beat.id),
                                      32'(wb_o.id));
                                check("wb_o.eew", 32'(m_flush ? m_ctx.eew : r.beat.eew),
                                      32'(wb_o.eew));
                                check("wb_o.vaddr", 32'(exp_vaddr), 32'(wb_o.vaddr));
                                check("wb_o.store", 32'(full && (m_flush ||
                                      (!r.beat.xreg && r.beat.res_valid))), 32'(wb_o.store));
                                check("wb_o.res_valid", 32'(m_flush || r.beat.res_valid),
                                      32'(wb_o.res_valid));
                                check("wb_o.shift", 32'((cnt % 4) < bytes), 32'(wb_o.shift));
                                check("wb_o.elemwise", 32'h1, 32'(wb_o.elemwise));
                                check("wb_o.mask", m_flush ? 32'h0 : 32'(r.beat.mask),
                                      32'(wb_o.mask));
                                if (!m_flush) begin
                                        check("wb_o.data", r.beat.res, wb_o.data);
                                end
                        end
                        if (r.exp_xreg_valid) begin
                                check("xreg_o.id", 32'(r.beat.id), 32'(xreg_o.id));
                                check("xreg_o.addr", 32'(r.beat.xreg_addr), 32'(xreg_o.addr));
                                check("xreg_o.data", r.beat.xreg_data, xreg_o.data);
                        end

                        if (r.ready) begin
                                m_cnt = cnt;
                                m_has = r.beat.res_valid || (m_has && !r.beat.first_cycle);
                                if (m_flush && full) begin
                                        m_flush = 1'b0;
                                end else if (!m_flush && r.valid && r.beat.last_cycle &&
                                             r.beat.requires_flush) begin
                                        m_flush = 1'b1;
                                        m_ctx   = r.beat;
                                end
                        end
                end

                $display("%0d rows, %0d checks, %0d errors", rows_q.size(), checks, errors);
                if (errors == 0) begin
                        $display("All tests passed!");
                end else begin
                        $display("Test failures found");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: hdl/elem_writeback.sv
// ----------------------------------------------------------------------
// element unit writeback that packs element results into whole vreg writes
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module elem_writeback #(
        parameter int unsigned VREG_W = 128
) (
        input  wire logic                              clk_i,
        input  wire logic                              async_rst_ni,
        input  wire logic                              beat_valid_i,
        input  wire elem_pipe_pkg::elem_beat_t         beat_i,
        output logic                                   beat_ready_o,
        output logic                                   out_valid_o,
        input  wire logic                              out_ready_i,
        output elem_pipe_pkg::wb_req_t                 wb_o,
        input  wire logic [elem_pipe_pkg::ID_CNT-1:0]  instr_spec_i,
        input  wire logic [elem_pipe_pkg::ID_CNT-1:0]  instr_killed_i,
        output elem_pipe_pkg::xreg_wr_t                xreg_o,
        output logic                                   instr_done_o,
        output logic                                   pend_clear_o,
        output vcfg_pkg::emul_e                        pend_clear_cnt_o
);

        localparam int unsigned CNT_W = $clog2(VREG_W/8) + vcfg_pkg::MUL_BITS;

        logic [CNT_W-1:0]          count_next;
        logic                      flushing;
        logic                      flush_end;
        elem_pipe_pkg::flush_ctx_t flush_ctx;

        elem_counter #(
                .VREG_W       ( VREG_W        )
        ) u_counter (
                .clk_i        ( clk_i         ),
                .async_rst_ni ( async_rst_ni  ),
                .beat_i       ( beat_i        ),
                .flushing_i   ( flushing      ),
                .flush_eew_i  ( flush_ctx.eew ),
                .out_ready_i  ( out_ready_i   ),
                .count_next_o ( count_next    )
        );

        flush_tracker u_flush (
                .clk_i        ( clk_i         ),
                .async_rst_ni ( async_rst_ni  ),
                .beat_valid_i ( beat_valid_i  ),
                .beat_i       ( beat_i        ),
                .out_ready_i  ( out_ready_i   ),
                .flush_end_i  ( flush_end     ),
                .flushing_o   ( flushing      ),
                .ctx_o        ( flush_ctx     )
        );

        result_writer #(
                .VREG_W           ( VREG_W           )
        ) u_writer (
                .beat_valid_i     ( beat_valid_i     ),
                .beat_i           ( beat_i           ),
                .count_next_i     ( count_next       ),
                .flushing_i       ( flushing         ),
                .ctx_i            ( flush_ctx        ),
                .out_ready_i      ( out_ready_i      ),
                .instr_spec_i     ( instr_spec_i     ),
                .instr_killed_i   ( instr_killed_i   ),
                .beat_ready_o     ( beat_ready_o     ),
                .out_valid_o      ( out_valid_o      ),
                .wb_o             ( wb_o             ),
                .xreg_o           ( xreg_o           ),
                .instr_done_o     ( instr_done_o     ),
                .pend_clear_o     ( pend_clear_o     ),
                .pend_clear_cnt_o ( pend_clear_cnt_o ),
                .flush_end_o      ( flush_end        )
        );

endmodule

`default_nettype wire

// File: hdl/result_writer.sv
// ----------------------------------------------------------------------
// builds the vreg write request, applies the speculation stall to xreg
// writes and raises the completion pulses
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module result_writer #(
        parameter int unsigned  VREG_W = 128,
        localparam int unsigned LOW_W  = $clog2(VREG_W/8),
        localparam int unsigned CNT_W  = LOW_W + vcfg_pkg::MUL_BITS
) (
        input  wire logic                              beat_valid_i,
        input  wire elem_pipe_pkg::elem_beat_t         beat_i,
        input  wire logic [CNT_W-1:0]                  count_next_i,
        input  wire logic                              flushing_i,
        input  wire elem_pipe_pkg::flush_ctx_t         ctx_i,
        input  wire logic                              out_ready_i,
        input  wire logic [elem_pipe_pkg::ID_CNT-1:0]  instr_spec_i,
        input  wire logic [elem_pipe_pkg::ID_CNT-1:0]  instr_killed_i,
        output logic                                   beat_ready_o,
        output logic                                   out_valid_o,
        output elem_pipe_pkg::wb_req_t                 wb_o,
        output elem_pipe_pkg::xreg_wr_t                xreg_o,
        output logic                                   instr_done_o,
        output logic                                   pend_clear_o,
        output vcfg_pkg::emul_e                        pend_clear_cnt_o,
        output logic                                   flush_end_o
);

        logic                            stall;
        logic                            low_full;
        logic                            last_plain;
        logic [vcfg_pkg::MUL_BITS-1:0]   count_mul;
        logic [vcfg_pkg::MUL_BITS-1:0]   mul_mask;
        vcfg_pkg::vaddr_t                base_vaddr;
        vcfg_pkg::vsew_e                 cur_eew;
        vcfg_pkg::emul_e                 cur_emul;

        // scalar results wait until the instruction is no longer speculative
        assign stall = beat_i.xreg_valid & instr_spec_i[beat_i.id];

        assign beat_ready_o = out_ready_i & ~flushing_i & ~stall;
        assign out_valid_o  = (beat_valid_i & ~stall) | flushing_i;

        assign low_full   = &count_next_i[LOW_W-1:0];
        assign count_mul  = count_next_i[CNT_W-1:LOW_W];
        assign base_vaddr = flushing_i ? ctx_i.vaddr : beat_i.vaddr;
        assign cur_eew    = flushing_i ? ctx_i.eew : beat_i.eew;
        assign cur_emul   = flushing_i ? ctx_i.emul : beat_i.emul;

        always_comb begin
                case (cur_emul)
                        vcfg_pkg::EMUL_2: mul_mask = 3'b001;
                        vcfg_pkg::EMUL_4: mul_mask = 3'b011;
                        vcfg_pkg::EMUL_8: mul_mask = 3'b111;
                        default:          mul_mask = 3'b000;
                endcase
        end

        always_comb begin
                wb_o.id        = flushing_i ? ctx_i.id : beat_i.id;
                wb_o.eew       = cur_eew;
                wb_o.vaddr     = base_vaddr | vcfg_pkg::vaddr_t'(count_mul & mul_mask);
                wb_o.store     = low_full & (flushing_i | (~beat_i.xreg & beat_i.res_valid));
                wb_o.res_valid = flushing_i | beat_i.res_valid;
                wb_o.elemwise  = 1'b1;
                wb_o.data      = beat_i.res;
                wb_o.mask      = flushing_i ? 4'b0000 : beat_i.mask; // filler beats write nothing
                // element lands at the bottom of a 32-bit word
                case (cur_eew)
                        vcfg_pkg::VSEW_8:  wb_o.shift = count_next_i[1:0] == 2'b00;
                        vcfg_pkg::VSEW_16: wb_o.shift = ~count_next_i[1];
                        vcfg_pkg::VSEW_32: wb_o.shift = 1'b1;
                        default:           wb_o.shift = 1'b0;
                endcase
        end

        always_comb begin
                xreg_o.valid = beat_valid_i & beat_i.xreg_valid & ~stall & ~flushing_i &
                               ~instr_killed_i[beat_i.id];
                xreg_o.id    = beat_i.id;
                xreg_o.addr  = beat_i.xreg_addr;
                xreg_o.data  = beat_i.xreg_data;
        end

        assign flush_end_o = flushing_i & low_full;
        assign last_plain  = beat_valid_i & ~flushing_i & beat_i.last_cycle &
                             ~beat_i.requires_flush;

        assign instr_done_o     = last_plain | flush_end_o;
        assign pend_clear_o     = (last_plain & ~beat_i.xreg) | flush_end_o;
        assign pend_clear_cnt_o = cur_emul;

endmodule

`default_nettype wire

// File: hdl/flush_tracker.sv
// ----------------------------------------------------------------------
// flush state of reduction-style instructions and the context captured
// from their last beat
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module flush_tracker (
        input  wire logic                       clk_i,
        input  wire logic                       async_rst_ni,
        input  wire logic                       beat_valid_i,
        input  wire elem_pipe_pkg::elem_beat_t  beat_i,
        input  wire logic                       out_ready_i,
        input  wire logic                       flush_end_i,
        output logic                            flushing_o,
        output elem_pipe_pkg::flush_ctx_t       ctx_o
);

        logic                      flushing_q;
        logic                      flushing_d;
        logic                      flush_start;
        elem_pipe_pkg::flush_ctx_t ctx_q;

        assign flush_start = ~flushing_q & beat_valid_i & beat_i.last_cycle &
                             beat_i.requires_flush;

        always_comb begin
                flushing_d = flushing_q;
                if (flush_start) begin
                        flushing_d = 1'b1;
                end
                if (flushing_q & flush_end_i) begin
                        flushing_d = 1'b0;
                end
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        flushing_q <= 1'b0;
                end else if (out_ready_i) begin
                        flushing_q <= flushing_d;
                end
        end

        // instruction context of the group being padded
        always_ff @(posedge clk_i) begin
                if (out_ready_i & flush_start) begin
                        ctx_q.id    <= beat_i.id;
                        ctx_q.eew   <= beat_i.eew;
                        ctx_q.emul  <= beat_i.emul;
                        ctx_q.vaddr <= beat_i.vaddr;
                end
        end

        assign flushing_o = flushing_q;
        assign ctx_o      = ctx_q;

endmodule

`default_nettype wire

// File: hdl/elem_counter.sv
// ----------------------------------------------------------------------
// byte counter over the destination register group, stepped by the
// element width of each valid result or flush beat
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module elem_counter #(
        parameter int unsigned  VREG_W = 128,
        localparam int unsigned LOW_W  = $clog2(VREG_W/8),
        localparam int unsigned CNT_W  = LOW_W + vcfg_pkg::MUL_BITS
) (
        input  wire logic                      clk_i,
        input  wire logic                      async_rst_ni,
        input  wire elem_pipe_pkg::elem_beat_t beat_i,
        input  wire logic                      flushing_i,
        input  wire vcfg_pkg::vsew_e           flush_eew_i,
        input  wire logic                      out_ready_i,
        output logic [CNT_W-1:0]               count_next_o
);

        logic [CNT_W-1:0] count_q;
        logic             has_res_q;
        logic             has_res_d;
        logic             first_res;
        vcfg_pkg::vsew_e  cur_eew;
        logic [2:0]       elem_bytes;
        logic [1:0]       elem_last; // bytes minus one

        assign cur_eew = flushing_i ? flush_eew_i : beat_i.eew;

        always_comb begin
                elem_bytes = '0;
                elem_last  = '0;
                case (cur_eew)
                        vcfg_pkg::VSEW_8: begin
                                elem_bytes = 3'd1;
                                elem_last  = 2'd0;
                        end
                        vcfg_pkg::VSEW_16: begin
                                elem_bytes = 3'd2;
                                elem_last  = 2'd1;
                        end
                        vcfg_pkg::VSEW_32: begin
                                elem_bytes = 3'd4;
                                elem_last  = 2'd3;
                        end
                        default: ;
                endcase
        end

        // cleared on first_cycle, set by any valid result
        always_comb begin
                has_res_d = beat_i.first_cycle ? 1'b0 : has_res_q;
                if (beat_i.res_valid) begin
                        has_res_d = 1'b1;
                end
        end

        assign first_res = ~flushing_i & beat_i.res_valid & (beat_i.first_cycle | ~has_res_q);

        always_comb begin
                count_next_o = count_q;
                if (flushing_i | beat_i.res_valid) begin
                        count_next_o = count_q + CNT_W'(elem_bytes);
                end
                if (first_res) begin
                        count_next_o = CNT_W'(elem_last); // restart at last byte of elem 0
                end
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (~async_rst_ni) begin
                        count_q   <= '0;
                        has_res_q <= 1'b0;
                end else if (out_ready_i) begin
                        count_q   <= count_next_o;
                        has_res_q <= has_res_d;
                end
        end

endmodule

`default_nettype wire

// File: hdl/elem_pipe_pkg.sv
// ----------------------------------------------------------------------
// element writeback structs for the element-unit beat, the vreg write
// request, the scalar write and the saved flush context
// ----------------------------------------------------------------------
`default_nettype none

package elem_pipe_pkg;

        localparam int unsigned ID_W   = 3;
        localparam int unsigned ID_CNT = 8;

        typedef logic [ID_W-1:0] id_t;

        typedef struct packed {
                id_t                 id;
                vcfg_pkg::vsew_e     eew;
                vcfg_pkg::emul_e     emul;
                vcfg_pkg::vaddr_t    vaddr;
                logic                first_cycle;
                logic                last_cycle;
                logic                requires_flush; // reductions pad the group
                logic                xreg;           // scalar destination
                logic                res_valid;
                logic                xreg_valid;
                logic [31:0]         res;
                logic [3:0]          mask;
                vcfg_pkg::xaddr_t    xreg_addr;
                logic [31:0]         xreg_data;
        } elem_beat_t;

        typedef struct packed {
                id_t                 id;
                vcfg_pkg::vsew_e     eew;
                vcfg_pkg::vaddr_t    vaddr;
                logic                store;    // commit the whole vreg
                logic                res_valid;
                logic                shift;
                logic                elemwise;
                logic [31:0]         data;
                logic [3:0]          mask;
        } wb_req_t;

        typedef struct packed {
                logic                valid;
                id_t                 id;
                vcfg_pkg::xaddr_t    addr;
                logic [31:0]         data;
        } xreg_wr_t;

        typedef struct packed {
                id_t                 id;
                vcfg_pkg::vsew_e     eew;
                vcfg_pkg::emul_e     emul;
                vcfg_pkg::vaddr_t    vaddr;
        } flush_ctx_t;

endpackage

`default_nettype wire

// File: hdl/vcfg_pkg.sv
// ----------------------------------------------------------------------
// vector configuration types for element width, group multiplier and
// vector and scalar register addresses
// ----------------------------------------------------------------------
`default_nettype none

package vcfg_pkg;

        // element width encoded as in vtype.vsew
        typedef enum logic [1:0] {
                VSEW_8  = 2'd0,
                VSEW_16 = 2'd1,
                VSEW_32 = 2'd2
        } vsew_e;

        // register group multiplier
        typedef enum logic [1:0] {
                EMUL_1 = 2'd0,
                EMUL_2 = 2'd1,
                EMUL_4 = 2'd2,
                EMUL_8 = 2'd3
        } emul_e;

        localparam int unsigned XREG_ADDR_W = 5;
        localparam int unsigned MUL_BITS    = 3; // up to 8 regs per group

        typedef logic [4:0]             vaddr_t;
        typedef logic [XREG_ADDR_W-1:0] xaddr_t;

endpackage

`default_nettype wire
